//--- Makefile
TOP = conv_loop_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f conv_loop.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- conv_loop.f
conv_loop_geom_pkg.sv
conv_loop_data_pkg.sv
fmap_loop_buffer.sv
pointwise_mac.sv
result_quantize.sv
conv_loop_top.sv
tb_clock_gen.sv
conv_loop_tb.sv

//--- conv_loop_data_pkg.sv
package conv_loop_data_pkg;
	import conv_loop_geom_pkg::*;

	// Scalar data types
	typedef logic signed [7:0]  pixel_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [23:0] acc_t;
	typedef logic [7:0]         uq8_t;

	// Index types
	typedef logic [pix_w-1:0] pix_idx_t;
	typedef logic [ci_w-1:0]  ci_idx_t;
	typedef logic [co_w-1:0]  co_idx_t;

	// Largest value an output result can hold
	localparam int result_max = 255;

	////////////////////////////////////////////////////////////
	// Port and stage bundles
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic    wr;
		co_idx_t co;
		ci_idx_t ci;
		weight_t value;
	} weight_wr_t;

	typedef struct packed {
		logic     valid;
		pixel_t   pixel;
		pix_idx_t pix;
		ci_idx_t  ci;
		co_idx_t  co;
	} replay_beat_t;

	typedef struct packed {
		logic     valid;
		acc_t     sum;
		pix_idx_t pix;
		co_idx_t  co;
	} acc_result_t;

	typedef struct packed {
		logic     valid;
		uq8_t     value;
		pix_idx_t pix;
		co_idx_t  co;
	} conv_result_t;

endpackage

//--- conv_loop_geom_pkg.sv
package conv_loop_geom_pkg;

	////////////////////////////////////////////////////////////
	// Image and channel sizes
	////////////////////////////////////////////////////////////

	localparam int img_w      = 4;
	localparam int img_size   = img_w * img_w;
	localparam int ch_in      = 3;
	localparam int ch_out     = 4;
	localparam int fmap_words = ch_in * img_size;

	// Idle cycles between replay passes, one row plus one
	localparam int replay_gap = img_w + 1;

	// Output scaling
	localparam int out_shift  = 4;

	////////////////////////////////////////////////////////////
	// Index widths
	////////////////////////////////////////////////////////////

	localparam int pix_w = $clog2(img_size);
	localparam int ci_w  = $clog2(ch_in);
	localparam int co_w  = $clog2(ch_out);

endpackage

//--- conv_loop_tb.sv
`timescale 1ns/1ps

module conv_loop_tb import conv_loop_geom_pkg::*, conv_loop_data_pkg::*; ();

	typedef enum int {
		fill_const,
		fill_ramp,
		fill_rand
	} fill_t;

	// One row of the stimulus table
	typedef struct {
		fill_t w_mode;
		int    w_base;
		int    w_step;
		fill_t p_mode;
		int    p_base;
		int    p_step;
		bit    junk;
	} case_t;

	localparam int num_cases      = 8;
	localparam int load_cycles    = 2 * fmap_words + ch_out * ch_in;
	localparam int busy_cycles    = ch_out * (fmap_words + replay_gap);
	localparam int frame_cycles   = load_cycles + busy_cycles + 20;
	localparam int timeout_cycles = num_cases * frame_cycles + 20;

	logic         clk;
	logic         reset;
	logic         valid_in;
	pixel_t       pixel_in;
	weight_wr_t   weight_wr;
	logic         busy;
	conv_result_t result;

	case_t        cases [num_cases];
	weight_t      w_cur [ch_out][ch_in];
	pixel_t       px_cur [fmap_words];
	conv_result_t exp_q [$];

	int seed;
	int value_errors;
	int other_errors;
	int frame_results;
	int cycles;

	tb_clock_gen clk_gen (
		.clk   (clk),
		.reset (reset)
	);

	conv_loop_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pixel_in  (pixel_in),
		.weight_wr (weight_wr),
		.busy      (busy),
		.result    (result)
	);

	////////////////////////////////////////////////////////////
	// Timeout and result monitor
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Results are stable away from the rising edge
	always @(negedge clk) begin
		if (!reset && result.valid) begin
			frame_results++;
			if (exp_q.size() == 0) begin
				$display("Unexpected result at %0t ns for output channel %0d pixel %0d",
					$time, result.co, result.pix);
				other_errors++;
			end else begin
				check_result(result, exp_q.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_result(input conv_result_t got, input conv_result_t exp);
		if (got.value !== exp.value) begin
			$display("[ERROR] %0t ns result.value got %0d expected %0d",
				$time, got.value, exp.value);
			value_errors++;
		end
		if (got.pix !== exp.pix) begin
			$display("[ERROR] %0t ns result.pix got %0d expected %0d",
				$time, got.pix, exp.pix);
			value_errors++;
		end
		if (got.co !== exp.co) begin
			$display("[ERROR] %0t ns result.co got %0d expected %0d",
				$time, got.co, exp.co);
			value_errors++;
		end
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns busy got %b expected %b", $time, got, exp);
			value_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////////////////////////

	task automatic fill_table;
		cases[0] = '{fill_const,    4, 0, fill_ramp,    0, 1, 1'b0};
		// Large products, every result clips
		cases[1] = '{fill_const,  127, 0, fill_const, 127, 0, 1'b0};
		// Negative sums only, with junk pixels during replay
		cases[2] = '{fill_const,   -5, 0, fill_ramp,    1, 2, 1'b1};
		cases[3] = '{fill_ramp,    -6, 1, fill_ramp,  -20, 3, 1'b0};
		cases[4] = '{fill_rand,     0, 0, fill_rand,    0, 0, 1'b1};
		cases[5] = '{fill_rand,     0, 0, fill_rand,    0, 0, 1'b0};
		cases[6] = '{fill_const,  100, 0, fill_rand,    0, 0, 1'b1};
		cases[7] = '{fill_rand,     0, 0, fill_ramp,    5, 7, 1'b0};
	endtask

	function automatic int fill_value(input fill_t mode, input int base, input int step,
		input int idx);
		int v;
		case (mode)
			fill_const: v = base;
			fill_ramp:  v = base + idx * step;
			default:    v = $random(seed);
		endcase
		return v;
	endfunction

	task automatic prepare_case(input int c);
		for (int co = 0; co < ch_out; co++) begin
			for (int ci = 0; ci < ch_in; ci++) begin
				w_cur[co][ci] = weight_t'(fill_value(cases[c].w_mode, cases[c].w_base,
					cases[c].w_step, co * ch_in + ci));
			end
		end
		for (int i = 0; i < fmap_words; i++) begin
			px_cur[i] = pixel_t'(fill_value(cases[c].p_mode, cases[c].p_base,
				cases[c].p_step, i));
		end
	endtask

	// Sum over input channels, then ReLU, shift and clip at 255
	task automatic build_expected;
		int sum;
		int q;
		conv_result_t e;
		for (int co = 0; co < ch_out; co++) begin
			for (int p = 0; p < img_size; p++) begin
				sum = 0;
				for (int ci = 0; ci < ch_in; ci++) begin
					sum += int'(px_cur[ci * img_size + p]) * int'(w_cur[co][ci]);
				end
				if (sum < 0) begin
					sum = 0;
				end
				q = sum >> out_shift;
				if (q > 255) begin
					q = 255;
				end
				e.valid = 1'b1;
				e.value = uq8_t'(q);
				e.pix   = pix_idx_t'(p);
				e.co    = co_idx_t'(co);
				exp_q.push_back(e);
			end
		end
	endtask

	task automatic write_weights;
		for (int co = 0; co < ch_out; co++) begin
			for (int ci = 0; ci < ch_in; ci++) begin
				@(negedge clk);
				weight_wr.wr    = 1'b1;
				weight_wr.co    = co_idx_t'(co);
				weight_wr.ci    = ci_idx_t'(ci);
				weight_wr.value = w_cur[co][ci];
			end
		end
		@(negedge clk);
		weight_wr = '0;
	endtask

	// Stream order with an idle cycle now and then
	task automatic load_frame;
		for (int i = 0; i < fmap_words; i++) begin
			if (i % 5 == 4) begin
				@(negedge clk);
				valid_in = 1'b0;
			end
			@(negedge clk);
			check_busy(busy, 1'b0);
			valid_in = 1'b1;
			pixel_in = px_cur[i];
		end
		@(negedge clk);
		valid_in = 1'b0;
		check_busy(busy, 1'b1);
	endtask

	task automatic wait_idle(input bit junk);
		int n;
		n = 0;
		while (busy) begin
			valid_in = junk;
			pixel_in = pixel_t'($random(seed));
			n++;
			@(negedge clk);
		end
		valid_in = 1'b0;
		if (n != busy_cycles) begin
			$display("Busy was high for %0d cycles instead of %0d", n, busy_cycles);
			other_errors++;
		end
	endtask

	task automatic run_case(input int c);
		frame_results = 0;
		prepare_case(c);
		write_weights();
		build_expected();
		load_frame();
		wait_idle(cases[c].junk);
		if (frame_results != ch_out * img_size) begin
			$display("Case %0d gave %0d results instead of %0d",
				c, frame_results, ch_out * img_size);
			other_errors++;
		end
		if (exp_q.size() != 0) begin
			$display("Case %0d left %0d expected results unmatched", c, exp_q.size());
			other_errors++;
			exp_q.delete();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		valid_in      = 1'b0;
		pixel_in      = '0;
		weight_wr     = '0;
		seed          = 33;
		value_errors  = 0;
		other_errors  = 0;
		frame_results = 0;
		cycles        = 0;
		fill_table();

		@(negedge clk);
		while (reset) begin
			@(negedge clk);
		end
		check_busy(busy, 1'b0);
		if (result.valid) begin
			$display("Result valid is high right after reset");
			other_errors++;
		end

		for (int c = 0; c < num_cases; c++) begin
			run_case(c);
		end
		repeat (4) @(negedge clk);

		$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- conv_loop_top.sv
`timescale 1ns/1ps

module conv_loop_top import conv_loop_data_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         valid_in,
	input  pixel_t       pixel_in,
	input  weight_wr_t   weight_wr,
	output logic         busy,
	output conv_result_t result
);

	////////////////////////////////////////////////////////////
	// Stage links
	////////////////////////////////////////////////////////////

	// Loop buffer to MAC
	replay_beat_t beat;

	// MAC to quantizer
	acc_result_t acc;

	////////////////////////////////////////////////////////////
	// Input side and loop buffer
	////////////////////////////////////////////////////////////

	// Holds one frame, replays it per output channel
	fmap_loop_buffer u_loop_buffer (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pixel_in (pixel_in),
		.busy     (busy),
		.beat     (beat)
	);

	////////////////////////////////////////////////////////////
	// Multiply-accumulate
	////////////////////////////////////////////////////////////

	// Two cycles from beat to sum
	pointwise_mac u_mac (
		.clk       (clk),
		.reset     (reset),
		.weight_wr (weight_wr),
		.beat      (beat),
		.acc       (acc)
	);

	////////////////////////////////////////////////////////////
	// Output side
	////////////////////////////////////////////////////////////

	// ReLU, shift and saturate, one cycle
	result_quantize u_quantize (
		.clk    (clk),
		.reset  (reset),
		.acc    (acc),
		.result (result)
	);

endmodule

//--- fmap_loop_buffer.sv
`timescale 1ns/1ps

module fmap_loop_buffer import conv_loop_geom_pkg::*, conv_loop_data_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         valid_in,
	input  pixel_t       pixel_in,
	output logic         busy,
	output replay_beat_t beat
);

	typedef enum logic [1:0] {
		st_load,
		st_replay,
		st_gap
	} state_t;

	state_t state;

	// One whole input map, channel outer and pixel inner
	pixel_t fmap_mem [fmap_words];

	logic [ci_w+pix_w-1:0] wr_addr;
	logic [ci_w+pix_w-1:0] rd_addr;

	ci_idx_t  rd_ci;
	pix_idx_t rd_pix;
	co_idx_t  pass_co;

	logic [$clog2(replay_gap)-1:0] gap_cnt;

	// img_size is a power of two, so the pixel index fills the low bits
	assign rd_addr = {rd_ci, rd_pix};

	assign busy = (state != st_load);

	////////////////////////////////////////////////////////////
	// Load / replay / gap sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_load;
			wr_addr <= '0;
			rd_ci   <= '0;
			rd_pix  <= '0;
			pass_co <= '0;
			gap_cnt <= '0;
		end else begin
			case (state)
				st_load: begin
					if (valid_in) begin
						if (wr_addr == ($bits(wr_addr))'(fmap_words - 1)) begin
							wr_addr <= '0;
							state   <= st_replay;
						end else begin
							wr_addr <= wr_addr + 1'b1;
						end
					end
				end

				st_replay: begin
					if (rd_pix == pix_idx_t'(img_size - 1)) begin
						rd_pix <= '0;
						if (rd_ci == ci_idx_t'(ch_in - 1)) begin
							rd_ci <= '0;
							state <= st_gap;
						end else begin
							rd_ci <= rd_ci + 1'b1;
						end
					end else begin
						rd_pix <= rd_pix + 1'b1;
					end
				end

				st_gap: begin
					if (gap_cnt == ($bits(gap_cnt))'(replay_gap - 1)) begin
						gap_cnt <= '0;
						// Last output channel done, take a new frame
						if (pass_co == co_idx_t'(ch_out - 1)) begin
							pass_co <= '0;
							state   <= st_load;
						end else begin
							pass_co <= pass_co + 1'b1;
							state   <= st_replay;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end

				default: begin
					state <= st_load;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel memory
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == st_load && valid_in) begin
			fmap_mem[wr_addr] <= pixel_in;
		end
	end

	// Registered read, beat fields follow the read by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			beat <= '0;
		end else begin
			beat.valid <= (state == st_replay);
			beat.pixel <= fmap_mem[rd_addr];
			beat.pix   <= rd_pix;
			beat.ci    <= rd_ci;
			beat.co    <= pass_co;
		end
	end

endmodule

//--- pointwise_mac.sv
`timescale 1ns/1ps

module pointwise_mac import conv_loop_geom_pkg::*, conv_loop_data_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  weight_wr_t   weight_wr,
	input  replay_beat_t beat,
	output acc_result_t  acc
);

	// Weight table, one row per output channel
	weight_t w_tab [ch_out][ch_in];

	// Running sums, one per pixel
	acc_t acc_mem [img_size];

	logic     s1_valid;
	acc_t     s1_prod;
	pix_idx_t s1_pix;
	ci_idx_t  s1_ci;
	co_idx_t  s1_co;

	acc_t sum_next;

	////////////////////////////////////////////////////////////
	// Weight load
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (weight_wr.wr) begin
			w_tab[weight_wr.co][weight_wr.ci] <= weight_wr.value;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 1, multiply
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= beat.valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_prod <= beat.pixel * w_tab[beat.co][beat.ci];
		s1_pix  <= beat.pix;
		s1_ci   <= beat.ci;
		s1_co   <= beat.co;
	end

	////////////////////////////////////////////////////////////
	// Stage 2, accumulate across input channels
	////////////////////////////////////////////////////////////

	// Channel 0 opens a fresh sum for the pixel
	always_comb begin
		if (s1_ci == '0) begin
			sum_next = s1_prod;
		end else begin
			sum_next = acc_mem[s1_pix] + s1_prod;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < img_size; i++) begin
				acc_mem[i] <= '0;
			end
			acc <= '0;
		end else begin
			if (s1_valid) begin
				acc_mem[s1_pix] <= sum_next;
			end
			// Only the last input channel completes a pixel
			acc.valid <= s1_valid && (s1_ci == ci_idx_t'(ch_in - 1));
			acc.sum   <= sum_next;
			acc.pix   <= s1_pix;
			acc.co    <= s1_co;
		end
	end

endmodule

//--- result_quantize.sv
`timescale 1ns/1ps

module result_quantize import conv_loop_geom_pkg::*, conv_loop_data_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  acc_result_t  acc,
	output conv_result_t result
);

	acc_t relu_sum;
	acc_t shifted;
	uq8_t value_next;

	// ReLU, scale down, clip to 8 bits
	always_comb begin
		if (acc.sum < 0) begin
			relu_sum = '0;
		end else begin
			relu_sum = acc.sum;
		end
		shifted = relu_sum >>> out_shift;
		if (shifted > acc_t'(result_max)) begin
			value_next = uq8_t'(result_max);
		end else begin
			value_next = uq8_t'(shifted);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else begin
			result.valid <= acc.valid;
			result.value <= value_next;
			result.pix   <= acc.pix;
			result.co    <= acc.co;
		end
	end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 4 ns period
	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// Reset spans two rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule
